//--- display_top.f
common/display_pkg.sv
common/seg7_pkg.sv
common/digit_if.sv
display/bcd_convert.sv
display/seg7_control.sv
display/display_top.sv
sim/display_tb.sv

//--- Makefile
# Verilator flow for the display subsystem testbench

VERILATOR ?= verilator
TOP       ?= display_tb
FILELIST  ?= display_top.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
PASS_TEXT ?= === PASS ===

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Output goes to the terminal and is searched in memory
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF "$(PASS_TEXT)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

//--- sim/display_tb.sv
`timescale 1ns/100ps

module display_tb;
    import display_pkg::*;

    localparam int SCAN_LIMIT   = 64;   // Cycles to wait for one anode
    localparam int WAIT_LIMIT   = 100;  // Conversion plus a full scan
    localparam int RANDOM_TESTS = 4;

    // Active-low gfedcba patterns for 0 to 9, read backwards to decode
    localparam logic [6:0] SEG_PATTERNS [10] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10
    };

    logic        CLK100MHz;
    logic        reset;
    logic        select;
    logic [31:0] result_in;
    logic [3:0]  data_in_ones;
    logic [3:0]  data_in_tens;
    logic [3:0]  data_in_hundreds;
    logic [3:0]  data_in_thousands;
    logic        deb_u;
    logic        deb_d;
    logic [3:0]  an_out;
    logic [6:0]  seg_out;
    logic [1:0]  leds_out;

    int     errors;
    int     checks;
    int     cycle;  // Free-running count for wait limits
    integer seed;

    // Test table, one entry per index
    string       tbl_name[$];
    logic        tbl_sel[$];
    logic [31:0] tbl_result[$];
    logic [15:0] tbl_data[$];     // Thousands down to ones
    string       tbl_presses[$];  // u for up, d for down
    logic [15:0] tbl_digits[$];   // Expected scan, same packing as data
    logic [1:0]  tbl_leds[$];

    // Expected display state while the table is built
    logic        model_sel;
    logic [31:0] model_result;
    int          model_page;

    display_top #(
        .refresh_bits (2)
    ) dut_i (
        .CLK100MHz         (CLK100MHz),
        .reset             (reset),
        .select            (select),
        .result_in         (result_in),
        .data_in_ones      (data_in_ones),
        .data_in_tens      (data_in_tens),
        .data_in_hundreds  (data_in_hundreds),
        .data_in_thousands (data_in_thousands),
        .deb_u             (deb_u),
        .deb_d             (deb_d),
        .an_out            (an_out),
        .seg_out           (seg_out),
        .leds_out          (leds_out)
    );

    initial begin
        CLK100MHz = 1'b0;
        cycle     = 0;
        forever #5 CLK100MHz = ~CLK100MHz;
    end

    always @(posedge CLK100MHz) cycle <= cycle + 1;

    // Four decimal digits of one page, by repeated division
    function automatic logic [15:0] decimal_page(input logic [31:0] value, input int page);
        logic [31:0] rest;
        logic [15:0] word;
        int          i;
        rest = value;
        for (i = 0; i < 4 * page; i++)
            rest = rest / 10;  // Drop the lower pages
        for (i = 0; i < 4; i++) begin
            word[4*i +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return word;
    endfunction

    function automatic logic [3:0] decode_segments(input logic [6:0] seg);
        int i;
        for (i = 0; i < 10; i++) begin
            if (seg == SEG_PATTERNS[i])
                return 4'(i);
        end
        return 4'hf;  // Blank or garbled
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Expected values follow the page rules, clamped to 0..LAST_PAGE
    task automatic add_test(input string name, input logic sel, input logic [31:0] result,
                            input logic [15:0] data, input string presses);
        int i;
        if (!sel) begin
            model_page = 0;
        end else if (!model_sel || result != model_result) begin
            model_page   = 0;  // New conversion opens on page 0
            model_result = result;
        end
        if (sel) begin
            for (i = 0; i < presses.len(); i++) begin
                if (presses[i] == "u" && model_page < LAST_PAGE)
                    model_page++;
                else if (presses[i] == "d" && model_page > 0)
                    model_page--;
            end
        end
        model_sel = sel;
        tbl_name.push_back(name);
        tbl_sel.push_back(sel);
        tbl_result.push_back(result);
        tbl_data.push_back(data);
        tbl_presses.push_back(presses);
        tbl_digits.push_back(sel ? decimal_page(result, model_page) : data);
        tbl_leds.push_back(2'(model_page));
    endtask

    // Page 0, up past the top, then down past the bottom
    task automatic add_paging(input string prefix, input logic [31:0] value);
        string steps [7];
        int    i;
        steps = '{"", "u", "u", "u", "d", "d", "d"};
        for (i = 0; i < 7; i++)
            add_test($sformatf("%s_step%0d", prefix, i), 1'b1, value, 16'h2468, steps[i]);
    endtask

    task automatic build_table();
        int r;
        add_test("input_1234", 1'b0, 32'd0, 16'h1234, "");
        add_test("input_9870_up", 1'b0, 32'd0, 16'h9870, "uu");
        add_test("input_0505_down", 1'b0, 32'd0, 16'h0505, "d");
        add_test("zero", 1'b1, 32'd0, 16'h0505, "");
        add_paging("max", 32'hffff_ffff);
        add_test("back_to_input", 1'b0, 32'hffff_ffff, 16'h4321, "u");
        add_paging("mid", 32'd12345678);
        add_paging("next", 32'd987654321);  // Select drops and rises again
        for (r = 0; r < RANDOM_TESTS; r++)
            add_paging($sformatf("random%0d", r), $random(seed));
    endtask

    // Single-cycle press, as from the debouncer
    task automatic press_button(input byte key);
        @(negedge CLK100MHz);
        deb_u = (key == "u");
        deb_d = (key == "d");
        @(negedge CLK100MHz);
        deb_u = 1'b0;
        deb_d = 1'b0;
    endtask

    // Follow the anodes through one scan and decode each position
    task automatic capture_scan(output logic [15:0] seen);
        int   pos;
        int   n;
        logic found;
        seen = 16'hffff;
        for (pos = 0; pos < 4; pos++) begin
            found = 1'b0;
            n     = 0;
            while (!found && n < SCAN_LIMIT) begin
                @(negedge CLK100MHz);
                n++;
                if (an_out == ~(4'b0001 << pos)) begin
                    found            = 1'b1;
                    seen[4*pos +: 4] = decode_segments(seg_out);
                end
            end
            if (!found) begin
                errors++;
                $display("Timeout: anode %0d never turned on within %0d cycles", pos, SCAN_LIMIT);
            end
        end
    endtask

    task automatic apply_test(input int idx);
        logic [15:0] seen;
        string       keys;
        int          start;
        int          i;
        logic        held;  // Same result stays on show, only the page may move
        keys = tbl_presses[idx];
        @(negedge CLK100MHz);
        held = tbl_sel[idx] && select && result_in == tbl_result[idx];
        if (tbl_sel[idx] && select && result_in != tbl_result[idx]) begin
            select = 1'b0;  // Another result needs a fresh rising edge
            @(negedge CLK100MHz);
            @(negedge CLK100MHz);
        end
        {data_in_thousands, data_in_hundreds, data_in_tens, data_in_ones} = tbl_data[idx];
        result_in = tbl_result[idx];
        select    = tbl_sel[idx];
        for (i = 0; i < keys.len(); i++)
            press_button(keys[i]);

        // A held result is right on the first scan, with no new conversion
        // Scan again until the display settles or time runs out
        start = cycle;
        capture_scan(seen);
        while (!held && (seen !== tbl_digits[idx] || leds_out !== tbl_leds[idx])
               && cycle - start < WAIT_LIMIT) begin
            capture_scan(seen);
        end
        check($sformatf("%s digits", tbl_name[idx]), 32'(tbl_digits[idx]), 32'(seen));
        check($sformatf("%s leds", tbl_name[idx]), 32'(tbl_leds[idx]), 32'(leds_out));
    endtask

    initial begin
        logic [15:0] seen;
        int          idx;
        seed              = 32'hb2f4b1ea;
        errors            = 0;
        checks            = 0;
        reset             = 1'b1;
        select            = 1'b0;
        result_in         = '0;
        data_in_ones      = '0;
        data_in_tens      = '0;
        data_in_hundreds  = '0;
        data_in_thousands = '0;
        deb_u             = 1'b0;
        deb_d             = 1'b0;
        model_sel         = 1'b0;
        model_result      = '0;
        model_page        = 0;
        build_table();

        repeat (2) @(posedge CLK100MHz);
        @(negedge CLK100MHz);
        reset = 1'b0;

        // Zeros everywhere straight out of reset
        capture_scan(seen);
        check("reset digits", 32'h0, 32'(seen));
        check("reset leds", 32'h0, 32'(leds_out));

        for (idx = 0; idx < tbl_name.size(); idx++)
            apply_test(idx);

        $display("Tests: %0d, checks: %0d, errors: %0d", tbl_name.size(), checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- display/display_top.sv
`timescale 1ns/100ps

module display_top #(
    parameter int refresh_bits = seg7_pkg::DEFAULT_REFRESH_BITS  // Passed to the scan driver
) (
    input  logic        CLK100MHz,
    input  logic        reset,
    input  logic        select,             // Low shows the operand, high the result
    input  logic [31:0] result_in,          // Unsigned calculator result
    input  logic [3:0]  data_in_ones,       // Operand digits
    input  logic [3:0]  data_in_tens,
    input  logic [3:0]  data_in_hundreds,
    input  logic [3:0]  data_in_thousands,
    input  logic        deb_u,              // Single-cycle page up press
    input  logic        deb_d,              // Single-cycle page down press
    output logic [3:0]  an_out,
    output logic [6:0]  seg_out,
    output logic [1:0]  leds_out            // Current page
);
    import display_pkg::*;

    digit_if digits ();

    logic        select_q;
    logic        select_rise;
    logic        conv_valid;      // Request toward the converter
    logic        conv_ready;
    result_t     conv_bin;
    logic        bcd_valid;
    bcd_result_t bcd_out;
    logic        issue;           // Raise a new request this cycle
    logic        accept;          // Handshake completes
    logic        capture;         // Keep the arriving result
    logic        need_conv;       // Request still owed behind an older one
    logic        req_current;     // Pending request belongs to this select period
    logic        flight_current;  // Conversion in progress belongs to it too
    logic        result_ready;
    bcd_result_t bcd_hold;        // Converted result, kept across page changes
    bcd_result_t bcd_src;
    page_t       page_q;
    page_t       page_d;
    logic [15:0] page_word;       // Four digits of the chosen page

    assign select_rise = select && !select_q;
    assign accept      = conv_valid && conv_ready;
    assign issue       = select && (select_rise || need_conv) && !conv_valid;
    assign capture     = bcd_valid && flight_current && select;  // Stale results fall away
    assign leds_out    = page_q;

    // Page moves within 0 to LAST_PAGE, back to 0 in input mode
    always_comb begin
        page_d = page_q;
        if (!select)
            page_d = '0;
        else if (deb_u && page_q < page_t'(LAST_PAGE))
            page_d = page_q + 1'b1;
        else if (deb_d && page_q != '0)
            page_d = page_q - 1'b1;
    end

    // A fresh result is shown straight from the converter
    assign bcd_src = capture ? bcd_out : bcd_hold;

    always_comb begin
        case (page_d)
            2'd0:    page_word = bcd_src[15:0];
            2'd1:    page_word = bcd_src[31:16];
            default: page_word = {8'h00, bcd_src[39:32]};  // Top two positions read zero
        endcase
    end

    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            select_q       <= 1'b0;
            conv_valid     <= 1'b0;
            need_conv      <= 1'b0;
            req_current    <= 1'b0;
            flight_current <= 1'b0;
            result_ready   <= 1'b0;
            page_q         <= '0;
        end else begin
            select_q <= select;
            page_q   <= page_d;

            if (issue)
                conv_valid <= 1'b1;
            else if (accept)
                conv_valid <= 1'b0;

            if (!select || issue)
                need_conv <= 1'b0;
            else if (select_rise)
                need_conv <= 1'b1;  // Old request still waiting, ask again afterwards

            if (!select)
                req_current <= 1'b0;
            else if (issue)
                req_current <= 1'b1;

            if (!select)
                flight_current <= 1'b0;
            else if (accept)
                flight_current <= req_current;

            if (!select)
                result_ready <= 1'b0;
            else if (capture)
                result_ready <= 1'b1;
        end
    end

    always_ff @(posedge CLK100MHz) begin
        if (issue)
            conv_bin <= result_in;
        if (capture)
            bcd_hold <= bcd_out;
    end

    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            digits.ones      <= '0;
            digits.tens      <= '0;
            digits.hundreds  <= '0;
            digits.thousands <= '0;
        end else if (!select) begin  // Operand digits, one cycle behind the inputs
            digits.ones      <= data_in_ones;
            digits.tens      <= data_in_tens;
            digits.hundreds  <= data_in_hundreds;
            digits.thousands <= data_in_thousands;
        end else if (result_ready || capture) begin
            {digits.thousands, digits.hundreds, digits.tens, digits.ones} <= page_word;
        end else begin
            // Zeros while the conversion runs
            digits.ones      <= '0;
            digits.tens      <= '0;
            digits.hundreds  <= '0;
            digits.thousands <= '0;
        end
    end

    bcd_convert conv_i (
        .CLK100MHz  (CLK100MHz),
        .reset      (reset),
        .conv_valid (conv_valid),
        .conv_ready (conv_ready),
        .conv_bin   (conv_bin),
        .bcd_valid  (bcd_valid),
        .bcd_out    (bcd_out)
    );

    seg7_control #(
        .refresh_bits (refresh_bits)
    ) scan_i (
        .CLK100MHz (CLK100MHz),
        .reset     (reset),
        .digits    (digits.sink),
        .an_out    (an_out),
        .seg_out   (seg_out)
    );

    // Button handling keeps the page in range
    a_page_range : assert property (@(posedge CLK100MHz) disable iff (reset)
        page_q <= page_t'(LAST_PAGE));

endmodule

//--- display/seg7_control.sv
`timescale 1ns/100ps

module seg7_control #(
    parameter int refresh_bits = seg7_pkg::DEFAULT_REFRESH_BITS  // log2 of cycles per digit
) (
    input  logic             CLK100MHz,
    input  logic             reset,
    digit_if.sink            digits,   // Four digits to show
    output seg7_pkg::anode_t an_out,   // Active-low digit enables
    output seg7_pkg::seg_t   seg_out   // Active-low cathodes
);
    import display_pkg::*;
    import seg7_pkg::*;

    logic [refresh_bits+1:0] refresh_cnt;  // Free-running, top two bits pick the digit
    logic [1:0]              digit_sel;
    logic                    scan_on;      // Low until the first slot has gone by
    digit_t                  cur_digit;

    assign digit_sel = refresh_cnt[refresh_bits+1 -: 2];

    // Scan order is ones, tens, hundreds, thousands
    always_comb begin
        case (digit_sel)
            2'd0:    cur_digit = digits.ones;
            2'd1:    cur_digit = digits.tens;
            2'd2:    cur_digit = digits.hundreds;
            default: cur_digit = digits.thousands;
        endcase
    end

    // Anode and cathode share one register stage so they switch together
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            refresh_cnt <= '0;
            scan_on     <= 1'b0;
            an_out      <= ANODE_OFF;
            seg_out     <= SEG_BLANK;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;

            // End of the first slot after reset
            if (&refresh_cnt[refresh_bits-1:0])
                scan_on <= 1'b1;

            if (scan_on) begin
                an_out  <= ~(anode_t'(1) << digit_sel);  // One anode pulled low
                seg_out <= seg7_encode(cur_digit);
            end
        end
    end

    // Two digits lit together would show a mix of both
    a_one_anode : assert property (@(posedge CLK100MHz) disable iff (reset)
        $onehot0(~an_out));

endmodule

//--- display/bcd_convert.sv
`timescale 1ns/100ps

module bcd_convert (
    input  logic                     CLK100MHz,
    input  logic                     reset,
    input  logic                     conv_valid,  // Request from controller
    output logic                     conv_ready,  // High while idle
    input  display_pkg::result_t     conv_bin,    // Value to convert
    output logic                     bcd_valid,   // One-cycle strobe with the result
    output display_pkg::bcd_result_t bcd_out
);
    import display_pkg::*;

    localparam int BIN_BITS    = $bits(result_t);
    localparam int BCD_BITS    = $bits(bcd_result_t);
    localparam int SHIFT_STEPS = CONVERT_CYCLES - 1;  // First cycle only loads
    localparam int STEP_BITS   = $clog2(SHIFT_STEPS);

    logic [BCD_BITS+BIN_BITS-1:0] shift_q;  // BCD digits on top, binary underneath
    logic [STEP_BITS-1:0]         step_q;   // Shift step in progress
    logic                         busy_q;
    bcd_result_t                  bcd_adj;  // Digits after the add-3 pass

    // True when every nibble is a decimal digit
    function automatic logic digits_valid(input bcd_result_t value);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < RESULT_DIGITS; i++) begin
            if (value[4*i +: 4] > 4'd9) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    assign conv_ready = !busy_q;
    assign bcd_out    = shift_q[BIN_BITS +: BCD_BITS];

    // Any digit of 5 or more would overflow on the shift, so add 3 first
    always_comb begin
        bcd_adj = shift_q[BIN_BITS +: BCD_BITS];
        for (int i = 0; i < RESULT_DIGITS; i++) begin
            if (bcd_adj[4*i +: 4] >= 4'd5) begin
                bcd_adj[4*i +: 4] = bcd_adj[4*i +: 4] + 4'd3;
            end
        end
    end

    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            busy_q    <= 1'b0;
            step_q    <= '0;
            bcd_valid <= 1'b0;
        end else begin
            bcd_valid <= 1'b0;  // Strobe lasts a single cycle
            if (!busy_q) begin
                if (conv_valid) begin  // Handshake completes here
                    busy_q <= 1'b1;
                    step_q <= '0;
                end
            end else if (step_q == STEP_BITS'(SHIFT_STEPS - 1)) begin
                busy_q    <= 1'b0;  // Last shift lands with the strobe
                bcd_valid <= 1'b1;
            end else begin
                step_q <= step_q + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK100MHz) begin
        if (!busy_q && conv_valid)
            shift_q <= {{BCD_BITS{1'b0}}, conv_bin};
        else if (busy_q)
            shift_q <= {bcd_adj, shift_q[BIN_BITS-1:0]} << 1;  // Next binary bit enters digit 0
    end

    // Fixed latency from acceptance to result
    a_latency : assert property (@(posedge CLK100MHz) disable iff (reset)
        conv_valid && conv_ready |-> ##CONVERT_CYCLES bcd_valid);

    // Result never holds a nibble above 9
    a_digits : assert property (@(posedge CLK100MHz) disable iff (reset)
        bcd_valid |-> digits_valid(bcd_out));

    // Waiting request keeps its value until taken
    a_req_stable : assert property (@(posedge CLK100MHz) disable iff (reset)
        conv_valid && !conv_ready |=> conv_valid && $stable(conv_bin));

endmodule

//--- common/digit_if.sv
`timescale 1ns/100ps

// Four digits on their way from the controller to the scan driver
interface digit_if;
    import display_pkg::*;

    digit_t ones;       // Rightmost position
    digit_t tens;
    digit_t hundreds;
    digit_t thousands;  // Leftmost position

    // Controller side
    modport source (
        output ones,
        output tens,
        output hundreds,
        output thousands
    );

    // Display driver side
    modport sink (
        input ones,
        input tens,
        input hundreds,
        input thousands
    );
endinterface

//--- common/seg7_pkg.sv
package seg7_pkg;

    typedef logic [6:0] seg_t;    // Active-low cathodes, bit 6 is g, bit 0 is a
    typedef logic [3:0] anode_t;  // Active-low anodes, bit 0 is the ones digit

    // Each digit stays lit for 2**18 cycles, about 2.6 ms at 100 MHz
    localparam int DEFAULT_REFRESH_BITS = 18;

    localparam seg_t   SEG_BLANK = 7'b111_1111;  // Every segment dark
    localparam anode_t ANODE_OFF = 4'b1111;      // No digit selected

    // Digit to cathode pattern, order gfedcba
    function automatic seg_t seg7_encode(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'b100_0000;
            4'd1:    return 7'b111_1001;
            4'd2:    return 7'b010_0100;
            4'd3:    return 7'b011_0000;
            4'd4:    return 7'b001_1001;
            4'd5:    return 7'b001_0010;
            4'd6:    return 7'b000_0010;
            4'd7:    return 7'b111_1000;
            4'd8:    return 7'b000_0000;
            4'd9:    return 7'b001_0000;
            default: return SEG_BLANK;  // Not a decimal digit
        endcase
    endfunction

endpackage

//--- common/display_pkg.sv
package display_pkg;

    // One decimal digit in BCD
    typedef logic [3:0] digit_t;

    // Raw calculator result, unsigned
    typedef logic [31:0] result_t;

    // Ten BCD digits, digit 0 sits in bits 3:0
    typedef logic [39:0] bcd_result_t;

    // Which group of four digits is on the display
    typedef logic [1:0] page_t;

    // Digits needed for the largest 32-bit value
    localparam int RESULT_DIGITS = 10;

    // Pages 0 and 1 hold four digits each, page 2 holds the top two
    localparam int LAST_PAGE = 2;

    // Load cycle plus one shift per result bit
    localparam int CONVERT_CYCLES = 33;

endpackage
